//--- include/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Datapath widths
`define LSU_DWIDTH        32
`define LSU_DMEM_AWIDTH   10

////////////////////////////////////////
// Address map
////////////////////////////////////////

// Top nibble that selects the data RAM
`define LSU_DMEM_REGION   4'h1
`define LSU_ADDR_CYCLE    32'h8000_0010
`define LSU_ADDR_INSTR    32'h8000_0014
`define LSU_ADDR_CTR_CLR  32'h8000_0018

// RISC-V load/store width codes
`define LSU_F3_B          3'd0
`define LSU_F3_H          3'd1
`define LSU_F3_W          3'd2
`define LSU_F3_BU         3'd4
`define LSU_F3_HU         3'd5

`endif

//--- design/lsu_pkg.sv
`default_nettype none
`include "lsu_consts.svh"

package lsu_pkg;

    // Legal targets only, errors are flagged separately
    typedef enum logic [1:0] {
        REGION_DMEM,
        REGION_CYCLE,
        REGION_INSTR,
        REGION_CTR_CLR
    } region_e;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [31:0]            paddr;
        logic [`LSU_DWIDTH-1:0] pwdata;
        logic [2:0]             funct3;
    } apb_req_t;

    typedef struct packed {
        logic                   pready;
        logic                   pslverr;
        logic [`LSU_DWIDTH-1:0] prdata;
    } apb_rsp_t;

    // Decoded request shared by the back end blocks
    typedef struct packed {
        logic                        setup;
        logic                        commit;
        logic                        access;
        logic                        err;
        region_e                     region;
        logic [`LSU_DMEM_AWIDTH-1:0] word_addr;
        logic [1:0]                  byte_off;
        logic [2:0]                  funct3;
        logic [`LSU_DWIDTH-1:0]      wdata;
    } mem_req_t;

endpackage

`default_nettype wire

//--- design/apb_front.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsu_consts.svh"

module apb_front import lsu_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire apb_req_t req,
    output mem_req_t      mem_req
);

    logic    setup_phase;
    logic    access_phase;
    logic    setup_seen;
    logic    orphan;
    logic    unmapped;
    logic    misaligned;
    logic    bad_dir;
    logic    decode_err;
    region_e region;

    assign setup_phase  = req.psel && !req.penable;
    assign access_phase = req.psel && req.penable;

    // Remembers that the previous cycle was a setup phase
    always_ff @(posedge clk) begin
        if (reset) begin
            setup_seen <= 1'b0;
        end else begin
            setup_seen <= setup_phase;
        end
    end

    assign orphan = access_phase && !setup_seen;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    always_comb begin
        unmapped = 1'b0;
        region   = REGION_DMEM;
        if (req.paddr[31:28] == `LSU_DMEM_REGION &&
            req.paddr[27:`LSU_DMEM_AWIDTH+2] == '0) begin
            region = REGION_DMEM;
        end else if (req.paddr == `LSU_ADDR_CYCLE) begin
            region = REGION_CYCLE;
        end else if (req.paddr == `LSU_ADDR_INSTR) begin
            region = REGION_INSTR;
        end else if (req.paddr == `LSU_ADDR_CTR_CLR) begin
            region = REGION_CTR_CLR;
        end else begin
            unmapped = 1'b1;
        end
    end

    // Halfwords on 2, words on 4; unknown codes are sized as words
    always_comb begin
        case (req.funct3)
            `LSU_F3_B, `LSU_F3_BU: misaligned = 1'b0;
            `LSU_F3_H, `LSU_F3_HU: misaligned = req.paddr[0];
            default:               misaligned = |req.paddr[1:0];
        endcase
    end

    // Counters are read only and the clear address is write only
    assign bad_dir = (req.pwrite && (region == REGION_CYCLE || region == REGION_INSTR)) ||
                     (!req.pwrite && region == REGION_CTR_CLR);

    assign decode_err = unmapped || misaligned || bad_dir;

    ////////////////////////////////////////
    // Internal request
    ////////////////////////////////////////

    always_comb begin
        mem_req.setup     = setup_phase && !decode_err;
        mem_req.access    = access_phase;
        mem_req.err       = decode_err || orphan;
        mem_req.commit    = access_phase && req.pwrite && !decode_err && !orphan;
        mem_req.region    = region;
        mem_req.word_addr = req.paddr[`LSU_DMEM_AWIDTH+1:2];
        mem_req.byte_off  = req.paddr[1:0];
        mem_req.funct3    = req.funct3;
        mem_req.wdata     = req.pwdata;
    end

    // Requester must move straight from setup into access
    setup_to_access: assert property (
        @(posedge clk) disable iff (reset)
        setup_phase |=> req.psel && req.penable
    ) else $error("apb_front: setup phase not followed by access phase");

endmodule

`default_nettype wire

//--- design/store_path.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsu_consts.svh"

module store_path import lsu_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire mem_req_t               mem_req,
    output logic [`LSU_DWIDTH-1:0]      ram_rdata
);

    localparam int BE_W  = `LSU_DWIDTH / 8;
    localparam int DEPTH = 1 << `LSU_DMEM_AWIDTH;

    logic [`LSU_DWIDTH-1:0] mem [0:DEPTH-1];
    logic [BE_W-1:0]        lanes;
    logic [BE_W-1:0]        byte_en;
    logic [`LSU_DWIDTH-1:0] lane_data;
    logic                   dmem_write;

    ////////////////////////////////////////
    // Lane alignment
    ////////////////////////////////////////

    // Lanes covered by the access, before the shift
    always_comb begin
        case (mem_req.funct3)
            `LSU_F3_B, `LSU_F3_BU: lanes = 4'b0001;
            `LSU_F3_H, `LSU_F3_HU: lanes = 4'b0011;
            default:               lanes = 4'b1111;
        endcase
    end

    assign dmem_write = mem_req.commit && mem_req.region == REGION_DMEM;
    assign byte_en    = dmem_write ? (lanes << mem_req.byte_off) : '0;

    // Store data moved up into its byte lane
    assign lane_data = mem_req.wdata << {mem_req.byte_off, 3'b000};

    ////////////////////////////////////////
    // Data RAM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int i = 0; i < BE_W; i++) begin
            if (byte_en[i]) begin
                mem[mem_req.word_addr][8*i +: 8] <= lane_data[8*i +: 8];
            end
        end
    end

    // Read launched in setup with data ready for the access cycle
    always_ff @(posedge clk) begin
        if (mem_req.setup && mem_req.region == REGION_DMEM) begin
            ram_rdata <= mem[mem_req.word_addr];
        end
    end

    // A RAM write always closes a transfer whose setup targeted the RAM
    write_after_setup: assert property (
        @(posedge clk) disable iff (reset)
        (|byte_en) |-> $past(mem_req.setup && mem_req.region == REGION_DMEM)
    ) else $error("store_path: byte enables without a preceding RAM setup");

endmodule

`default_nettype wire

//--- design/perf_counters.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsu_consts.svh"

module perf_counters import lsu_pkg::*; (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              retire,
    input  wire mem_req_t          mem_req,
    output logic [`LSU_DWIDTH-1:0] cycle_count,
    output logic [`LSU_DWIDTH-1:0] instr_count
);

    logic ctr_clr;

    // Store to the clear address, taken at the end of its access cycle
    assign ctr_clr = mem_req.commit && mem_req.region == REGION_CTR_CLR;

    ////////////////////////////////////////
    // Counters
    ////////////////////////////////////////

    // Clear beats a retire in the same cycle
    always_ff @(posedge clk) begin
        if (reset || ctr_clr) begin
            cycle_count <= '0;
            instr_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
            if (retire) begin
                instr_count <= instr_count + 1'b1;
            end
        end
    end

    // A clear must come from a setup that was decoded to the clear address
    clear_from_setup: assert property (
        @(posedge clk) disable iff (reset)
        ctr_clr |-> $past(mem_req.setup && mem_req.region == REGION_CTR_CLR)
    ) else $error("perf_counters: counter clear without matching setup");

endmodule

`default_nettype wire

//--- design/load_return.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsu_consts.svh"

module load_return import lsu_pkg::*; (
    input  wire mem_req_t               mem_req,
    input  wire logic [`LSU_DWIDTH-1:0] ram_rdata,
    input  wire logic [`LSU_DWIDTH-1:0] cycle_count,
    input  wire logic [`LSU_DWIDTH-1:0] instr_count,
    output apb_rsp_t                    rsp
);

    logic [`LSU_DWIDTH-1:0] src_word;
    logic [`LSU_DWIDTH-1:0] shifted;
    logic [`LSU_DWIDTH-1:0] load_data;
    logic                   read_ok;

    ////////////////////////////////////////
    // Source select and extraction
    ////////////////////////////////////////

    always_comb begin
        case (mem_req.region)
            REGION_DMEM:  src_word = ram_rdata;
            REGION_CYCLE: src_word = cycle_count;
            REGION_INSTR: src_word = instr_count;
            default:      src_word = '0;
        endcase
    end

    // Addressed byte or halfword down to bit 0
    assign shifted = src_word >> {mem_req.byte_off, 3'b000};

    always_comb begin
        case (mem_req.funct3)
            `LSU_F3_B:  load_data = {{(`LSU_DWIDTH-8){shifted[7]}}, shifted[7:0]};
            `LSU_F3_H:  load_data = {{(`LSU_DWIDTH-16){shifted[15]}}, shifted[15:0]};
            `LSU_F3_BU: load_data = {{(`LSU_DWIDTH-8){1'b0}}, shifted[7:0]};
            `LSU_F3_HU: load_data = {{(`LSU_DWIDTH-16){1'b0}}, shifted[15:0]};
            default:    load_data = shifted;
        endcase
    end

    ////////////////////////////////////////
    // APB response
    ////////////////////////////////////////

    // Legal access that is not a write commit is a read
    assign read_ok = mem_req.access && !mem_req.err && !mem_req.commit;

    always_comb begin
        rsp.pready  = mem_req.access;
        rsp.pslverr = mem_req.access && mem_req.err;
        rsp.prdata  = read_ok ? load_data : '0;
    end

endmodule

`default_nettype wire

//--- design/lsu_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsu_consts.svh"

module lsu_top import lsu_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire apb_req_t req,
    input  wire logic     retire,
    output apb_rsp_t      rsp
);

    mem_req_t               mem_req;
    logic [`LSU_DWIDTH-1:0] ram_rdata;
    logic [`LSU_DWIDTH-1:0] cycle_count;
    logic [`LSU_DWIDTH-1:0] instr_count;

    ////////////////////////////////////////
    // Request decode
    ////////////////////////////////////////

    apb_front u_apb_front (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .mem_req (mem_req)
    );

    ////////////////////////////////////////
    // RAM and counters, side by side
    ////////////////////////////////////////

    store_path u_store_path (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .ram_rdata (ram_rdata)
    );

    perf_counters u_perf_counters (
        .clk         (clk),
        .reset       (reset),
        .retire      (retire),
        .mem_req     (mem_req),
        .cycle_count (cycle_count),
        .instr_count (instr_count)
    );

    // Read response
    load_return u_load_return (
        .mem_req     (mem_req),
        .ram_rdata   (ram_rdata),
        .cycle_count (cycle_count),
        .instr_count (instr_count),
        .rsp         (rsp)
    );

endmodule

`default_nettype wire

//--- dv/lsu_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsu_consts.svh"

module lsu_tb import lsu_pkg::*; ();

    localparam int          TIMEOUT_CYCLES   = 8;
    localparam int          RANDOM_TRANSFERS = 600;
    localparam int          BYTE_AW          = `LSU_DMEM_AWIDTH + 2;
    localparam logic [31:0] DMEM_BASE        = {`LSU_DMEM_REGION, 28'h0};

    logic     clk;
    logic     reset;
    logic     retire;
    apb_req_t req;
    apb_rsp_t rsp;

    integer      seed;
    int          checks;
    int          value_errors;
    int          other_errors;
    logic        retire_force;
    logic        clr_now;
    logic [31:0] m_cycles;
    logic [31:0] m_instr;
    logic [7:0]  ram_model [0:(1 << BYTE_AW)-1];

    lsu_top u_lsu_top (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .retire (retire),
        .rsp    (rsp)
    );

    always #20 clk = ~clk;

    // Counter model, clear taken at the edge ending the clear store
    always @(posedge clk) begin
        if (reset || clr_now) begin
            m_cycles <= '0;
            m_instr  <= '0;
        end else begin
            m_cycles <= m_cycles + 32'd1;
            if (retire) begin
                m_instr <= m_instr + 32'd1;
            end
        end
    end

    ////////////////////////////////////////
    // Reference rules
    ////////////////////////////////////////

    function automatic logic access_error(input logic write, input logic [31:0] addr,
                                          input logic [2:0] f3);
        logic dmem;
        logic ctr_ro;
        logic clr;
        logic misaligned;
        dmem   = addr[31:28] == `LSU_DMEM_REGION && addr[27:BYTE_AW] == '0;
        ctr_ro = addr == `LSU_ADDR_CYCLE || addr == `LSU_ADDR_INSTR;
        clr    = addr == `LSU_ADDR_CTR_CLR;
        case (f3)
            `LSU_F3_H, `LSU_F3_HU: misaligned = addr[0];
            `LSU_F3_W:             misaligned = addr[1:0] != 2'b00;
            default:               misaligned = 1'b0;
        endcase
        return !(dmem || ctr_ro || clr) || misaligned || (write && ctr_ro) || (!write && clr);
    endfunction

    // RISC-V load result taken from one aligned word
    function automatic logic [31:0] load_value(input logic [31:0] word, input logic [1:0] off,
                                               input logic [2:0] f3);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[{off, 3'b000} +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (f3)
            `LSU_F3_B:  return {{24{b[7]}}, b};
            `LSU_F3_BU: return {24'h0, b};
            `LSU_F3_H:  return {{16{h[15]}}, h};
            `LSU_F3_HU: return {16'h0, h};
            default:    return word;
        endcase
    endfunction

    function automatic logic [31:0] ram_word(input logic [31:0] addr);
        logic [BYTE_AW-1:0] base;
        base = {addr[BYTE_AW-1:2], 2'b00};
        return {ram_model[base+3], ram_model[base+2], ram_model[base+1], ram_model[base]};
    endfunction

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        #2;
        r      = $random(seed);
        retire = retire_force ? 1'b1 : r[0];
    endtask

    task automatic apb_transfer(input logic write, input logic [31:0] addr, input logic [2:0] f3,
                                input logic [31:0] wdata, input string name,
                                output logic [31:0] rdata);
        int                 waited;
        logic               exp_err;
        logic [31:0]        exp_data;
        logic [BYTE_AW-1:0] a;
        exp_err = access_error(write, addr, f3);
        a       = addr[BYTE_AW-1:0];
        next_cycle();
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = write;
        req.paddr   = addr;
        req.pwdata  = wdata;
        req.funct3  = f3;
        next_cycle();
        req.penable = 1'b1;
        clr_now     = write && !exp_err && addr == `LSU_ADDR_CTR_CLR;
        waited      = 0;
        @(negedge clk);
        while (!rsp.pready && waited < TIMEOUT_CYCLES) begin
            waited++;
            @(negedge clk);
        end
        rdata = rsp.prdata;
        if (!rsp.pready) begin
            other_errors++;
            $display("%s: no pready within %0d cycles of the access phase", name, TIMEOUT_CYCLES);
        end else begin
            if (exp_err || write) begin
                exp_data = '0;
            end else if (addr == `LSU_ADDR_CYCLE) begin
                exp_data = load_value(m_cycles, 2'b00, f3);
            end else if (addr == `LSU_ADDR_INSTR) begin
                exp_data = load_value(m_instr, 2'b00, f3);
            end else begin
                exp_data = load_value(ram_word(addr), addr[1:0], f3);
            end
            checks++;
            assert (waited == 0) else begin
                other_errors++;
                $display("%s: pready came %0d cycles after the first access cycle", name, waited);
            end
            assert (rsp.pslverr == exp_err) else begin
                value_errors++;
                $display("error %s pslverr: expected %0b, actual %0b", name, exp_err, rsp.pslverr);
            end
            assert (rsp.prdata == exp_data) else begin
                value_errors++;
                $display("error %s prdata: expected %h, actual %h", name, exp_data, rsp.prdata);
            end
        end
        next_cycle();
        req.psel    = 1'b0;
        req.penable = 1'b0;
        clr_now     = 1'b0;
        // Store bytes land at the address and upwards
        if (write && !exp_err && addr[31:28] == `LSU_DMEM_REGION) begin
            ram_model[a] = wdata[7:0];
            if (f3 != `LSU_F3_B) begin
                ram_model[a+1] = wdata[15:8];
            end
            if (f3 == `LSU_F3_W) begin
                ram_model[a+2] = wdata[23:16];
                ram_model[a+3] = wdata[31:24];
            end
        end
    endtask

    task automatic random_transfer(input int n);
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [2:0]  f3;
        r     = $random(seed);
        r2    = $random(seed);
        wdata = $random(seed);
        case (r[3:0])
            4'd10:   addr = `LSU_ADDR_CYCLE;
            4'd11:   addr = `LSU_ADDR_INSTR;
            4'd12:   addr = `LSU_ADDR_CTR_CLR;
            4'd13:   addr = r2;
            4'd14:   addr = DMEM_BASE | 32'h0000_1000 | {20'h0, r2[11:0]};
            4'd15:   addr = DMEM_BASE | {20'h0, r2[11:0]};
            default: addr = DMEM_BASE | {26'h0, r2[5:0]};
        endcase
        if (r[4]) begin
            f3 = r[6:5] == 2'd0 ? `LSU_F3_B : (r[6:5] == 2'd1 ? `LSU_F3_H : `LSU_F3_W);
        end else begin
            case (r[7:5])
                3'd0:    f3 = `LSU_F3_B;
                3'd1:    f3 = `LSU_F3_H;
                3'd3:    f3 = `LSU_F3_BU;
                3'd4:    f3 = `LSU_F3_HU;
                default: f3 = `LSU_F3_W;
            endcase
        end
        apb_transfer(r[4], addr, f3, wdata, $sformatf("random %0d", n), rdata);
        repeat (r[9:8]) next_cycle();
    endtask

    initial begin
        logic [31:0] rdata;
        seed         = 32'h9e01_5c69;
        clk          = 1'b0;
        reset        = 1'b1;
        retire       = 1'b0;
        req          = '0;
        retire_force = 1'b0;
        clr_now      = 1'b0;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        assert (rsp == '0) else begin
            value_errors++;
            $display("error reset response: expected %h, actual %h", 34'h0, rsp);
        end

        // Whole RAM gets a pattern from its word address
        for (int w = 0; w < (1 << `LSU_DMEM_AWIDTH); w++) begin
            apb_transfer(1'b1, DMEM_BASE | (w << 2), `LSU_F3_W,
                         {6'h2b, w[9:0], 6'h15, ~w[9:0]}, "fill", rdata);
        end

        // Sub-word stores and loads
        apb_transfer(1'b1, DMEM_BASE + 32'h21, `LSU_F3_B, 32'h0000_00a5, "store byte", rdata);
        apb_transfer(1'b0, DMEM_BASE + 32'h21, `LSU_F3_B, '0, "load byte", rdata);
        apb_transfer(1'b0, DMEM_BASE + 32'h21, `LSU_F3_BU, '0, "load byte unsigned", rdata);
        apb_transfer(1'b1, DMEM_BASE + 32'h22, `LSU_F3_H, 32'h0000_8001, "store half", rdata);
        apb_transfer(1'b0, DMEM_BASE + 32'h22, `LSU_F3_H, '0, "load half", rdata);
        apb_transfer(1'b0, DMEM_BASE + 32'h22, `LSU_F3_HU, '0, "load half unsigned", rdata);
        apb_transfer(1'b0, DMEM_BASE + 32'h20, `LSU_F3_W, '0, "load word", rdata);

        // Error completions, then the RAM word is untouched
        apb_transfer(1'b1, DMEM_BASE + 32'h41, `LSU_F3_W, 32'hdead_beef, "misaligned word", rdata);
        apb_transfer(1'b1, DMEM_BASE + 32'h43, `LSU_F3_H, 32'h0000_beef, "misaligned half", rdata);
        apb_transfer(1'b0, DMEM_BASE + 32'h45, `LSU_F3_HU, '0, "misaligned load", rdata);
        apb_transfer(1'b1, `LSU_ADDR_CYCLE, `LSU_F3_W, 32'h1234_5678, "counter store", rdata);
        apb_transfer(1'b0, `LSU_ADDR_CTR_CLR, `LSU_F3_W, '0, "clear address load", rdata);
        apb_transfer(1'b0, 32'h2000_0000, `LSU_F3_W, '0, "unmapped load", rdata);
        apb_transfer(1'b0, DMEM_BASE + 32'h40, `LSU_F3_W, '0, "word after errors", rdata);

        // Retire held high over the clear; two edges follow it before the read
        retire_force = 1'b1;
        apb_transfer(1'b1, `LSU_ADDR_CTR_CLR, `LSU_F3_W, '0, "counter clear", rdata);
        apb_transfer(1'b0, `LSU_ADDR_INSTR, `LSU_F3_W, '0, "instr after clear", rdata);
        assert (rdata == 32'd2) else begin
            value_errors++;
            $display("error instr after clear: expected %h, actual %h", 32'd2, rdata);
        end
        apb_transfer(1'b1, `LSU_ADDR_CTR_CLR, `LSU_F3_W, '0, "counter clear", rdata);
        apb_transfer(1'b0, `LSU_ADDR_CYCLE, `LSU_F3_W, '0, "cycle after clear", rdata);
        assert (rdata == 32'd2) else begin
            value_errors++;
            $display("error cycle after clear: expected %h, actual %h", 32'd2, rdata);
        end
        retire_force = 1'b0;

        for (int n = 0; n < RANDOM_TRANSFERS; n++) begin
            random_transfer(n);
        end

        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
design/lsu_pkg.sv
design/apb_front.sv
design/store_path.sv
design/perf_counters.sv
design/load_return.sv
design/lsu_top.sv
dv/lsu_tb.sv

//--- run.sh
#!/bin/sh
# Builds and runs the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module lsu_tb -o lsu_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/lsu_tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
fi
exit 1
